// ==== logic/merge_pkg.sv ====
/*
 * Shared definitions for the merge data generator
 * Lane, field and FIFO sizing constants
 * Engine packet struct, lane and ops mask types
 * Setup state machine encoding
 */

package merge_pkg;

    // ----------------------------------------
    // Sizing
    // ----------------------------------------
    localparam int merge_lanes = 4;
    localparam int num_fields  = 4;
    localparam int field_w     = 32;
    localparam int meta_w      = 16;

    // ----------------------------------------
    // FIFO geometry
    // ----------------------------------------
    localparam int fifo_depth  = 16;
    localparam int fifo_addr_w = 4;
    // Leaves room for merges still in flight when the pause kicks in
    localparam int prog_thresh = 8;

    // ----------------------------------------
    // Packet and mask types
    // ----------------------------------------
    // 16 bits of meta followed by the data fields, 144 bits total
    typedef struct packed {
        logic [meta_w-1:0]                 meta;
        logic [num_fields-1:0][field_w-1:0] field;
    } engine_packet_t;

    // One bit per input lane
    typedef logic [merge_lanes-1:0] lane_mask_t;

    // ops_mask[lane][field] selects that lane's field 0 for the output field
    typedef logic [merge_lanes-1:0][num_fields-1:0] ops_mask_t;

    // ----------------------------------------
    // Setup state machine
    // ----------------------------------------
    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_setup_idle,
        st_setup_req,
        st_setup_wait,
        st_start,
        st_busy,
        st_pause
    } merge_state_t;

endpackage : merge_pkg

// ==== logic/packet_fifo.sv ====
/*
 * Synchronous first-word-fall-through FIFO of engine packets
 * Occupancy count drives empty, full and programmable-full
 */

`timescale 1ns/1ps

module packet_fifo
    import merge_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           wr_en,
    input  engine_packet_t din,
    input  logic           rd_en,
    output engine_packet_t dout,
    output logic           empty,
    output logic           full,
    output logic           prog_full
);

    engine_packet_t         mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;
    logic                   do_wr;
    logic                   do_rd;

    // Guard against overflow and underflow
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry is always visible
    assign dout = mem[rd_ptr];

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty     = (count == '0);
    assign full      = (count == fifo_depth);
    assign prog_full = (count >= prog_thresh);

    // Producer and consumer must respect the flags
    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full
    ) else $error("packet_fifo: write while full");

    a_no_read_when_empty : assert property (
        @(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty
    ) else $error("packet_fifo: read while empty");

endmodule : packet_fifo

// ==== logic/merge_config_fsm.sv ====
/*
 * Setup state machine for the merge data generator
 * Requests and captures the merge configuration,
 * enables merging and pauses on output programmable-full
 */

`timescale 1ns/1ps

module merge_config_fsm
    import merge_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  logic       config_request,
    input  logic       config_valid,
    input  lane_mask_t config_merge_mask,
    input  ops_mask_t  config_ops_mask,
    input  logic       out_prog_full,
    output logic       config_setup,
    output logic       merge_enable,
    output lane_mask_t merge_mask,
    output ops_mask_t  ops_mask,
    output logic       running
);

    merge_state_t state;
    merge_state_t next_state;

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset:      next_state = st_idle;
            st_idle:       next_state = st_setup_idle;
            st_setup_idle: begin
                if (config_request) begin
                    next_state = st_setup_req;
                end
            end
            st_setup_req:  next_state = st_setup_wait;
            st_setup_wait: begin
                if (config_valid) begin
                    next_state = st_start;
                end
            end
            st_start:      next_state = st_busy;
            st_busy: begin
                if (out_prog_full) begin
                    next_state = st_pause;
                end
            end
            st_pause: begin
                if (!out_prog_full) begin
                    next_state = st_busy;
                end
            end
            default:       next_state = st_reset;
        endcase
    end

    // ----------------------------------------
    // Configuration capture
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == st_setup_wait && config_valid) begin
            merge_mask <= config_merge_mask;
            ops_mask   <= config_ops_mask;
        end
    end

    // Setup strobe lasts exactly the one cycle spent in st_setup_req
    assign config_setup = (state == st_setup_req);
    assign merge_enable = (state == st_busy);
    assign running      = (state inside {st_start, st_busy, st_pause});

    // Lane 0 supplies meta, so it has to be part of every merge
    a_mask_has_lane0 : assert property (
        @(posedge ap_clk) disable iff (areset_generator) running |-> merge_mask[0]
    ) else $error("merge_config_fsm: merge mask without lane 0");

endmodule : merge_config_fsm

// ==== logic/field_merge_stage.sv ====
/*
 * All-or-nothing pop across the masked lanes
 * Registered field merge into one output packet
 */

`timescale 1ns/1ps

module field_merge_stage
    import merge_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           merge_enable,
    input  lane_mask_t     merge_mask,
    input  ops_mask_t      ops_mask,
    input  logic           lane_valid [merge_lanes],
    input  engine_packet_t lane_data [merge_lanes],
    output logic           lane_pop [merge_lanes],
    output logic           merged_valid,
    output engine_packet_t merged_data
);

    logic           fire;
    engine_packet_t merged_next;

    // ----------------------------------------
    // Pop decision
    // ----------------------------------------
    always_comb begin
        fire = merge_enable;
        for (int i = 0; i < merge_lanes; i++) begin
            if (merge_mask[i] && !lane_valid[i]) begin
                fire = 1'b0;
            end
        end
        for (int i = 0; i < merge_lanes; i++) begin
            lane_pop[i] = fire & merge_mask[i];
        end
    end

    // ----------------------------------------
    // Field selection
    // ----------------------------------------
    always_comb begin
        merged_next = lane_data[0];
        // Ascending scan so the highest masked lane wins
        for (int j = 0; j < num_fields; j++) begin
            for (int i = 0; i < merge_lanes; i++) begin
                if (merge_mask[i] && ops_mask[i][j]) begin
                    merged_next.field[j] = lane_data[i].field[0];
                end
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            merged_valid <= 1'b0;
        end else begin
            merged_valid <= fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fire) begin
            merged_data <= merged_next;
        end
    end

    // Masks are captured once per setup and hold while merging
    a_masks_stable : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            merge_enable |-> ($stable(merge_mask) && $stable(ops_mask))
    ) else $error("field_merge_stage: masks changed while merging");

endmodule : field_merge_stage

// ==== logic/merge_data_generator.sv ====
/*
 * Merge data generator top level
 * Input and output registers, four lane FIFOs,
 * setup FSM, field merge stage and output FIFO
 */

`timescale 1ns/1ps

module merge_data_generator
    import merge_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           response_valid [merge_lanes],
    input  engine_packet_t response_data [merge_lanes],
    output logic           response_full [merge_lanes],
    input  logic           config_request,
    input  logic           config_valid,
    input  lane_mask_t     config_merge_mask,
    input  ops_mask_t      config_ops_mask,
    output logic           config_setup,
    input  logic           request_ready,
    output logic           request_valid,
    output engine_packet_t request_data,
    output logic           done
);

    logic           response_valid_reg [merge_lanes];
    engine_packet_t response_data_reg [merge_lanes];
    logic           config_request_reg;
    logic           config_valid_reg;
    lane_mask_t     config_merge_mask_reg;
    ops_mask_t      config_ops_mask_reg;
    logic           request_ready_reg;

    logic           lane_valid [merge_lanes];
    engine_packet_t lane_data [merge_lanes];
    logic           lane_pop [merge_lanes];
    logic           lane_empty [merge_lanes];
    logic           lane_prog_full [merge_lanes];
    logic           lanes_empty;

    logic           config_setup_int;
    logic           merge_enable;
    lane_mask_t     merge_mask;
    ops_mask_t      ops_mask;
    logic           running;
    logic           merged_valid;
    engine_packet_t merged_data;

    logic           out_pop;
    logic           out_empty;
    logic           out_prog_full;
    engine_packet_t out_dout;

    // ----------------------------------------
    // Input registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_request_reg <= 1'b0;
            config_valid_reg   <= 1'b0;
            request_ready_reg  <= 1'b0;
            for (int i = 0; i < merge_lanes; i++) begin
                response_valid_reg[i] <= 1'b0;
            end
        end else begin
            config_request_reg <= config_request;
            config_valid_reg   <= config_valid;
            request_ready_reg  <= request_ready;
            for (int i = 0; i < merge_lanes; i++) begin
                response_valid_reg[i] <= response_valid[i];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        config_merge_mask_reg <= config_merge_mask;
        config_ops_mask_reg   <= config_ops_mask;
        for (int i = 0; i < merge_lanes; i++) begin
            response_data_reg[i] <= response_data[i];
        end
    end

    // ----------------------------------------
    // Lane FIFOs
    // ----------------------------------------
    for (genvar i = 0; i < merge_lanes; i++) begin : g_lane
        packet_fifo lane_fifo_inst (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .wr_en            (response_valid_reg[i]),
            .din              (response_data_reg[i]),
            .rd_en            (lane_pop[i]),
            .dout             (lane_data[i]),
            .empty            (lane_empty[i]),
            .full             (),
            .prog_full        (lane_prog_full[i])
        );

        assign lane_valid[i] = ~lane_empty[i];
    end

    always_comb begin
        lanes_empty = 1'b1;
        for (int i = 0; i < merge_lanes; i++) begin
            lanes_empty = lanes_empty & lane_empty[i];
        end
    end

    // ----------------------------------------
    // Setup FSM and merge stage
    // ----------------------------------------
    merge_config_fsm merge_config_fsm_inst (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .config_request    (config_request_reg),
        .config_valid      (config_valid_reg),
        .config_merge_mask (config_merge_mask_reg),
        .config_ops_mask   (config_ops_mask_reg),
        .out_prog_full     (out_prog_full),
        .config_setup      (config_setup_int),
        .merge_enable      (merge_enable),
        .merge_mask        (merge_mask),
        .ops_mask          (ops_mask),
        .running           (running)
    );

    field_merge_stage field_merge_stage_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .ops_mask         (ops_mask),
        .lane_valid       (lane_valid),
        .lane_data        (lane_data),
        .lane_pop         (lane_pop),
        .merged_valid     (merged_valid),
        .merged_data      (merged_data)
    );

    // ----------------------------------------
    // Output FIFO
    // ----------------------------------------
    assign out_pop = ~out_empty & request_ready_reg;

    packet_fifo out_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (merged_valid),
        .din              (merged_data),
        .rd_en            (out_pop),
        .dout             (out_dout),
        .empty            (out_empty),
        .full             (),
        .prog_full        (out_prog_full)
    );

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_setup  <= 1'b0;
            request_valid <= 1'b0;
            done          <= 1'b0;
            for (int i = 0; i < merge_lanes; i++) begin
                response_full[i] <= 1'b0;
            end
        end else begin
            config_setup  <= config_setup_int;
            request_valid <= out_pop;
            // A merge held in the stage register is not drained yet
            done          <= running & lanes_empty & out_empty & ~merged_valid;
            // Raised early so the two writes still in flight fit
            for (int i = 0; i < merge_lanes; i++) begin
                response_full[i] <= lane_prog_full[i];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        request_data <= out_dout;
    end

endmodule : merge_data_generator

// ==== dv/merge_data_generator_tb.sv ====
/*
 * Testbench for the merge data generator
 * Clock, reset, stimulus table and merge model
 * Output ordering, setup strobe and done checks
 */

`timescale 1ns/1ps

module merge_data_generator_tb
    import merge_pkg::*;
();

    localparam int num_rows   = 5;
    localparam int max_pkts   = 16;
    localparam int wait_limit = 2000;

    typedef struct packed {
        lane_mask_t merge_mask;
        ops_mask_t  ops_mask;
        logic [4:0] num_pkts;
        logic       hold_en;
        logic [1:0] hold_lane;
        logic       ready_low;
    } row_t;

    logic           ap_clk;
    logic           areset_generator;
    logic           response_valid [merge_lanes];
    engine_packet_t response_data [merge_lanes];
    logic           response_full [merge_lanes];
    logic           config_request;
    logic           config_valid;
    lane_mask_t     config_merge_mask;
    ops_mask_t      config_ops_mask;
    logic           config_setup;
    logic           request_ready;
    logic           request_valid;
    engine_packet_t request_data;
    logic           done;

    row_t           rows [num_rows];
    engine_packet_t sent_pkts [merge_lanes][max_pkts];
    engine_packet_t exp_pkts [max_pkts];
    int             rx_count;
    logic           send_done;
    int             setup_pulses;
    int             checks;
    int             errors;

    merge_data_generator merge_data_generator_inst (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .response_valid    (response_valid),
        .response_data     (response_data),
        .response_full     (response_full),
        .config_request    (config_request),
        .config_valid      (config_valid),
        .config_merge_mask (config_merge_mask),
        .config_ops_mask   (config_ops_mask),
        .config_setup      (config_setup),
        .request_ready     (request_ready),
        .request_valid     (request_valid),
        .request_data      (request_data),
        .done              (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #20 ap_clk = ~ap_clk;
        end
    end

    // Setup strobes seen since the last reset
    always @(negedge ap_clk) begin
        if (config_setup === 1'b1) begin
            setup_pulses++;
        end
    end

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic idle_inputs();
        config_request    = 1'b0;
        config_valid      = 1'b0;
        config_merge_mask = '0;
        config_ops_mask   = '0;
        request_ready     = 1'b0;
        for (int i = 0; i < merge_lanes; i++) begin
            response_valid[i] = 1'b0;
            response_data[i]  = '0;
        end
    endtask

    task automatic apply_reset();
        @(negedge ap_clk);
        areset_generator = 1'b1;
        idle_inputs();
        setup_pulses = 0;
        repeat (2) @(negedge ap_clk);
        areset_generator = 1'b0;
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Highest masked lane with the ops bit set supplies its field 0
    function automatic engine_packet_t expected_merge(input row_t r, input int k);
        engine_packet_t res;
        int             src;
        res.meta = sent_pkts[0][k].meta;
        for (int j = 0; j < num_fields; j++) begin
            src = -1;
            for (int i = merge_lanes - 1; i >= 0; i--) begin
                if (src < 0 && r.merge_mask[i] && r.ops_mask[i][j]) begin
                    src = i;
                end
            end
            if (src < 0) begin
                res.field[j] = sent_pkts[0][k].field[j];
            end else begin
                res.field[j] = sent_pkts[src][k].field[0];
            end
        end
        return res;
    endfunction

    task automatic build_packets(input row_t r);
        for (int k = 0; k < int'(r.num_pkts); k++) begin
            for (int i = 0; i < merge_lanes; i++) begin
                sent_pkts[i][k].meta = 16'($urandom);
                for (int j = 0; j < num_fields; j++) begin
                    sent_pkts[i][k].field[j] = $urandom;
                end
            end
            exp_pkts[k] = expected_merge(r, k);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic logic lane_blocked(input lane_mask_t lanes);
        logic blocked;
        blocked = 1'b0;
        for (int i = 0; i < merge_lanes; i++) begin
            if (lanes[i] && response_full[i]) begin
                blocked = 1'b1;
            end
        end
        return blocked;
    endfunction

    task automatic send_beat(input lane_mask_t lanes, input int k);
        int waited;
        waited = 0;
        @(negedge ap_clk);
        for (int i = 0; i < merge_lanes; i++) begin
            response_valid[i] = 1'b0;
        end
        while (lane_blocked(lanes)) begin
            waited++;
            if (waited > wait_limit) begin
                abort_on_timeout("lane FIFO stayed full");
            end
            @(negedge ap_clk);
        end
        for (int i = 0; i < merge_lanes; i++) begin
            if (lanes[i]) begin
                response_valid[i] = 1'b1;
                response_data[i]  = sent_pkts[i][k];
            end
        end
    endtask

    task automatic release_lanes();
        @(negedge ap_clk);
        for (int i = 0; i < merge_lanes; i++) begin
            response_valid[i] = 1'b0;
        end
    endtask

    task automatic request_setup(input row_t r);
        int waited;
        waited = 0;
        config_request = 1'b1;
        while (config_setup !== 1'b1) begin
            @(negedge ap_clk);
            waited++;
            if (waited > wait_limit) begin
                abort_on_timeout("config_setup never pulsed");
            end
        end
        @(negedge ap_clk);
        checks++;
        if (config_setup !== 1'b0) begin
            $display("CHECK FAILED config_setup width: got %h expected %h", config_setup, 1'b0);
            errors++;
        end
        config_request    = 1'b0;
        config_valid      = 1'b1;
        config_merge_mask = r.merge_mask;
        config_ops_mask   = r.ops_mask;
        @(negedge ap_clk);
        config_valid = 1'b0;
    endtask

    task automatic send_packets(input row_t r);
        lane_mask_t held;
        held = '0;
        if (r.hold_en) begin
            held[r.hold_lane] = 1'b1;
        end
        for (int k = 0; k < int'(r.num_pkts); k++) begin
            send_beat(r.merge_mask & ~held, k);
        end
        release_lanes();
        if (r.hold_en) begin
            // Held lane must stall every merge
            repeat (30) begin
                @(negedge ap_clk);
                checks++;
                if (request_valid !== 1'b0) begin
                    $display("CHECK FAILED request_valid during lane hold: got %h expected %h",
                             request_valid, 1'b0);
                    errors++;
                end
            end
            for (int k = 0; k < int'(r.num_pkts); k++) begin
                send_beat(held, k);
            end
            release_lanes();
        end
        send_done = 1'b1;
    endtask

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    task automatic collect_outputs(input row_t r);
        int idle;
        int hold;
        idle = 0;
        hold = 0;
        while (rx_count < int'(r.num_pkts)) begin
            @(negedge ap_clk);
            if (request_valid === 1'b1) begin
                checks++;
                if (request_data !== exp_pkts[rx_count]) begin
                    $display("CHECK FAILED request_data packet %0d: got %h expected %h",
                             rx_count, request_data, exp_pkts[rx_count]);
                    errors++;
                end
                // Output FIFO still held this packet, so nothing is drained yet
                checks++;
                if (done !== 1'b0) begin
                    $display("CHECK FAILED done before drain: got %h expected %h", done, 1'b0);
                    errors++;
                end
                rx_count++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > wait_limit) begin
                abort_on_timeout("request_valid stopped arriving");
            end
            // Consumer stays stalled until the output FIFO has backed up
            if (r.ready_low && (!send_done || hold < 60)) begin
                request_ready = 1'b0;
                if (send_done) begin
                    hold++;
                end
            end else begin
                request_ready = (($urandom % 4) != 0);
            end
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (done !== 1'b1) begin
            @(negedge ap_clk);
            waited++;
            checks++;
            if (request_valid !== 1'b0) begin
                $display("CHECK FAILED request_valid after last packet: got %h expected %h",
                         request_valid, 1'b0);
                errors++;
            end
            if (waited > wait_limit) begin
                abort_on_timeout("done never rose after drain");
            end
        end
    endtask

    task automatic run_row(input row_t r);
        apply_reset();
        @(negedge ap_clk);
        checks++;
        if (request_valid !== 1'b0 || config_setup !== 1'b0 || done !== 1'b0) begin
            $display("CHECK FAILED request_valid/config_setup/done after reset: got %h expected %h",
                     {request_valid, config_setup, done}, 3'b000);
            errors++;
        end
        for (int i = 0; i < merge_lanes; i++) begin
            if (response_full[i] !== 1'b0) begin
                $display("CHECK FAILED response_full[%0d] after reset: got %h expected %h",
                         i, response_full[i], 1'b0);
                errors++;
            end
        end
        build_packets(r);
        rx_count  = 0;
        send_done = 1'b0;
        request_setup(r);
        fork
            send_packets(r);
            collect_outputs(r);
        join
        wait_done();
        checks++;
        if (setup_pulses != 1) begin
            $display("CHECK FAILED setup_pulses: got %h expected %h", setup_pulses, 1);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    initial begin
        void'($urandom(32'hf402));
        areset_generator = 1'b1;
        idle_inputs();
        checks       = 0;
        errors       = 0;
        setup_pulses = 0;
        rx_count     = 0;
        send_done    = 1'b0;

        // Lane 0 alone
        rows[0] = '{merge_mask: 4'b0001, ops_mask: 16'h0000, num_pkts: 5'd4,
                    hold_en: 1'b0, hold_lane: 2'd0, ready_low: 1'b0};
        // All lanes, one field each
        rows[1] = '{merge_mask: 4'b1111, ops_mask: 16'h8420, num_pkts: 5'd6,
                    hold_en: 1'b0, hold_lane: 2'd0, ready_low: 1'b0};
        // Overlapping ops bits, lane 2 unmasked
        rows[2] = '{merge_mask: 4'b1011, ops_mask: 16'h6870, num_pkts: 5'd5,
                    hold_en: 1'b0, hold_lane: 2'd0, ready_low: 1'b0};
        // Lane 2 holds back its packets
        rows[3] = '{merge_mask: 4'b0111, ops_mask: 16'h0240, num_pkts: 5'd4,
                    hold_en: 1'b1, hold_lane: 2'd2, ready_low: 1'b0};
        // Consumer stalled long enough to hit programmable-full
        rows[4] = '{merge_mask: 4'b1111, ops_mask: 16'hf0f0, num_pkts: 5'd12,
                    hold_en: 1'b0, hold_lane: 2'd0, ready_low: 1'b1};

        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end
        finish_run();
    end

endmodule : merge_data_generator_tb

// ==== sim.f ====
logic/merge_pkg.sv
logic/packet_fifo.sv
logic/merge_config_fsm.sv
logic/field_merge_stage.sv
logic/merge_data_generator.sv
dv/merge_data_generator_tb.sv

// ==== Makefile ====
# Verilator build and run for the merge data generator

TOP := merge_data_generator_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
